// File: ibuff.f
verilog/ibuff_pkg.sv
verilog/ibuff_ptr_ctrl.sv
verilog/ibuff_line_store.sv
verilog/ibuff_window_align.sv
verilog/ibuff_top.sv
testbench/tb_icache_model.sv
testbench/tb_ibuff.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_ibuff -f ibuff.f -o tb_ibuff \
    || { echo "verilator build failed"; exit 1; }

sim_out=$(./obj_dir/tb_ibuff)
echo "$sim_out"

echo "$sim_out" | grep -q "Simulation finished: PASS" && exit 0 || exit 1

// File: testbench/tb_ibuff.sv
`timescale 1ns/1ps

module tb_ibuff import ibuff_pkg::*; ();

    localparam int CLK_PERIOD  = 4;
    localparam int WALK_STEPS  = 40;
    localparam int MISS_CYCLES = 5;
    localparam int HOLD_CYCLES = 6;
    // reset, fill, walk, flush, stall, full buffer
    localparam int PLANNED_CYCLES = 2 + 3 + (WALK_STEPS + 1) + 6 + (MISS_CYCLES + 8)
                                    + (HOLD_CYCLES + 7);

    logic              clk;
    logic              reset;
    logic              flush;
    fetch_addr_u       flush_addr;
    consume_t          consume_len;
    logic              fetch_req;
    logic [LINE_W-1:0] fetch_line_even;
    logic [LINE_W-1:0] fetch_line_odd;
    line_t             line_even;
    line_t             line_odd;
    logic              miss_even;
    logic              miss_odd;
    logic              inject_even;
    logic              inject_odd;
    line_t             window;
    logic              window_valid;
    fetch_addr_u       window_addr;

    integer seed;
    int     err_count;
    int     check_count;
    int     test_count;

    ibuff_top dut_i (
        .clk             (clk),
        .reset           (reset),
        .flush           (flush),
        .flush_addr      (flush_addr),
        .fetch_req       (fetch_req),
        .fetch_line_even (fetch_line_even),
        .fetch_line_odd  (fetch_line_odd),
        .line_even       (line_even),
        .line_odd        (line_odd),
        .miss_even       (miss_even),
        .miss_odd        (miss_odd),
        .consume_len     (consume_len),
        .window          (window),
        .window_valid    (window_valid),
        .window_addr     (window_addr)
    );

    tb_icache_model icache_i (
        .fetch_line_even (fetch_line_even),
        .fetch_line_odd  (fetch_line_odd),
        .inject_even     (inject_even),
        .inject_odd      (inject_odd),
        .line_even       (line_even),
        .line_odd        (line_odd),
        .miss_even       (miss_even),
        .miss_odd        (miss_odd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(PLANNED_CYCLES * CLK_PERIOD * 2);
        $display("Watchdog: tests did not complete within %0d cycles", PLANNED_CYCLES * 2);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // 16 bytes the consumer should see starting at addr
    function automatic line_t expected_window(input fetch_addr_u addr);
        line_t             w;
        logic [ADDR_W-1:0] a;
        int                b;
        w = '0;
        for (b = 0; b < LINE_BYTES; b++) begin
            a = addr + ADDR_W'(b);
            w[b*8 +: 8] = 8'(a * 7 + 3);
        end
        return w;
    endfunction

    task automatic compare_window(input string what, input line_t got, input line_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Error at %0t ns: %s window %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_addr(input string what, input fetch_addr_u got,
                                input fetch_addr_u exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Error at %0t ns: %s address %h (line %h offset %h), expected %h",
                     $time, what, got, got.ln.line, got.ln.offset, exp);
        end
    endtask

    task automatic compare_line(input string what, input logic [LINE_W-1:0] got,
                                input logic [LINE_W-1:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Error at %0t ns: %s %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_flag(input string what, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic wait_window(input string what, input int max_edges);
        int n;
        bit seen;
        seen = 1'b0;
        n = 0;
        while (!seen && n < max_edges) begin
            @(negedge clk);
            seen = window_valid;
            n++;
        end
        check_count++;
        if (!seen) begin
            err_count++;
            $display("%s: window never became valid within %0d clock edges", what, max_edges);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        $display("test %s done with %0d errors", name, err_count - errs_before);
    endtask

    task automatic reset_and_fill();
        int errs;
        errs = err_count;
        @(posedge clk);
        @(negedge clk);
        compare_flag("window_valid in reset", window_valid, 1'b0);
        @(posedge clk);
        reset <= 1'b0;   // second reset edge
        wait_window("reset fill", 2);
        compare_addr("reset fill", window_addr, '0);
        compare_window("reset fill", window, expected_window('0));
        report_test("reset_and_fill", errs);
    endtask

    task automatic consume_walk(input int steps, input fetch_addr_u start);
        int          errs;
        int          i;
        fetch_addr_u exp_addr;
        line_t       prev_window;
        bit          hold;
        consume_t    len;
        errs = err_count;
        exp_addr = start;
        hold = 1'b0;
        prev_window = '0;
        for (i = 0; i < steps; i++) begin
            @(negedge clk);
            compare_addr("consume walk", window_addr, exp_addr);
            if (window_valid) begin
                compare_window("consume walk", window, expected_window(exp_addr));
                if (hold) begin
                    compare_window("zero consume", window, prev_window);
                end
                // the length on the input now is taken at the coming edge
                exp_addr = fetch_addr_u'(exp_addr + ADDR_W'(consume_len));
            end
            hold = window_valid && consume_len == '0;
            prev_window = window;
            len = (i == steps - 1) ? '0 : consume_t'($unsigned($random(seed)) % 17);
            @(posedge clk);
            consume_len <= len;
        end
        @(negedge clk);
        compare_addr("consume walk end", window_addr, exp_addr);
        report_test("consume_walk", errs);
    endtask

    task automatic flush_redirect();
        int          errs;
        fetch_addr_u target;
        errs = err_count;
        target = '0;
        target.pr.pair   = 'h12;
        target.pr.bank   = 1'b1;   // odd line, window spills into the next pair
        target.pr.offset = 4'h9;
        @(posedge clk);
        flush      <= 1'b1;
        flush_addr <= target;
        @(posedge clk);
        flush <= 1'b0;
        wait_window("flush redirect", 3);
        compare_addr("flush redirect", window_addr, target);
        compare_window("flush redirect", window, expected_window(target));
        report_test("flush_redirect", errs);
    endtask

    task automatic miss_stall(input int miss_cycles, output fetch_addr_u target);
        int errs;
        errs = err_count;
        target = '0;
        target.pr.pair = 'h20;
        target.pr.bank = 1'b1;
        @(posedge clk);
        flush       <= 1'b1;
        flush_addr  <= target;
        inject_even <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        repeat (miss_cycles) begin
            @(negedge clk);
            compare_flag("fetch_req during miss", fetch_req, 1'b1);
            compare_flag("window_valid during miss", window_valid, 1'b0);
            compare_line("even line during miss", fetch_line_even, target.ln.line - 1'b1);
            compare_line("odd line during miss", fetch_line_odd, target.ln.line);
        end
        @(posedge clk);
        inject_even <= 1'b0;
        inject_odd  <= 1'b1;   // odd bank misses alone for one more cycle
        @(negedge clk);
        compare_flag("fetch_req during odd miss", fetch_req, 1'b1);
        compare_flag("window_valid during odd miss", window_valid, 1'b0);
        @(posedge clk);
        inject_odd <= 1'b0;
        wait_window("miss stall", 2);
        compare_addr("miss stall", window_addr, target);
        compare_window("miss stall", window, expected_window(target));
        report_test("miss_stall", errs);
    endtask

    task automatic flow_limit(input int hold_cycles, input fetch_addr_u start);
        int          errs;
        int          n;
        fetch_addr_u next;
        errs = err_count;
        next = fetch_addr_u'(start + ADDR_W'(LINE_BYTES));
        n = 0;
        while (fetch_req && n < 4) begin
            @(negedge clk);
            n++;
        end
        check_count++;
        if (fetch_req) begin
            err_count++;
            $display("flow limit: fetch_req stayed high with the buffer full");
        end
        repeat (hold_cycles) begin
            @(negedge clk);
            compare_flag("fetch_req while full", fetch_req, 1'b0);
            compare_flag("window_valid while full", window_valid, 1'b1);
        end
        @(posedge clk);
        consume_len <= 5'd16;
        @(posedge clk);
        consume_len <= '0;   // the 16 is taken at this edge
        @(negedge clk);
        compare_addr("flow limit", window_addr, next);
        compare_flag("fetch_req after line crossing", fetch_req, 1'b1);
        compare_flag("window_valid after line crossing", window_valid, 1'b1);
        compare_window("flow limit", window, expected_window(next));
        report_test("flow_limit", errs);
    endtask

    initial begin
        fetch_addr_u stall_addr;
        seed        = 32'hbf9b;
        err_count   = 0;
        check_count = 0;
        test_count  = 0;
        reset       = 1'b1;
        flush       = 1'b0;
        flush_addr  = '0;
        consume_len = '0;
        inject_even = 1'b0;
        inject_odd  = 1'b0;

        reset_and_fill();
        consume_walk(WALK_STEPS, '0);
        flush_redirect();
        miss_stall(MISS_CYCLES, stall_addr);
        flow_limit(HOLD_CYCLES, stall_addr);

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: testbench/tb_icache_model.sv
`timescale 1ns/1ps

module tb_icache_model import ibuff_pkg::*; (
    input  logic [LINE_W-1:0] fetch_line_even,
    input  logic [LINE_W-1:0] fetch_line_odd,
    input  logic              inject_even,
    input  logic              inject_odd,
    output line_t             line_even,
    output line_t             line_odd,
    output logic              miss_even,
    output logic              miss_odd
);

    // byte b of line n holds (16n + b) * 7 + 3
    function automatic line_t line_bytes(input logic [LINE_W-1:0] n);
        line_t             l;
        logic [ADDR_W-1:0] a;
        int                b;
        l = '0;
        for (b = 0; b < LINE_BYTES; b++) begin
            a = {n, 4'(b)};
            l[b*8 +: 8] = 8'(a * 7 + 3);
        end
        return l;
    endfunction

    assign line_even = line_bytes(fetch_line_even);
    assign line_odd  = line_bytes(fetch_line_odd);
    assign miss_even = inject_even;   // test holds these for as long as it wants a miss
    assign miss_odd  = inject_odd;

endmodule

// File: verilog/ibuff_line_store.sv
`timescale 1ns/1ps

module ibuff_line_store import ibuff_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  line_t                 line_even,
    input  line_t                 line_odd,
    input  logic [NUM_SLOTS-1:0]  ld,
    input  logic [NUM_SLOTS-1:0]  inval,
    output logic [NUM_SLOTS-1:0]  valid,
    output line_t [NUM_SLOTS-1:0] slot_data
);

    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
        line_t bank_line;

        // slots 0 and 2 hold even lines, 1 and 3 odd lines
        assign bank_line = (i % 2 == 0) ? line_even : line_odd;

        always_ff @(posedge clk) begin
            if (reset) begin
                valid[i] <= 1'b0;
            end else if (inval[i]) begin
                valid[i] <= 1'b0;      // invalidate wins over a same-cycle load
            end else if (ld[i]) begin
                valid[i] <= 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (ld[i]) begin
                slot_data[i] <= bank_line;
            end
        end
    end

endmodule

// File: verilog/ibuff_pkg.sv
package ibuff_pkg;

    localparam int LINE_BYTES = 16;
    localparam int NUM_SLOTS  = 4;   // slot = line number mod 4
    localparam int ADDR_W     = 32;
    localparam int LINE_W     = ADDR_W - $clog2(LINE_BYTES);

    // one cache line, byte 0 in bits 7:0
    typedef logic [LINE_BYTES*8-1:0] line_t;

    // bytes taken by the consumer this cycle, 0 to 16
    typedef logic [4:0] consume_t;

    // byte address seen either as line + offset or as pair + bank + offset
    typedef union packed {
        struct packed {
            logic [LINE_W-1:0]             line;
            logic [$clog2(LINE_BYTES)-1:0] offset;
        } ln;
        struct packed {
            logic [LINE_W-2:0]             pair;
            logic                          bank;    // set for odd lines
            logic [$clog2(LINE_BYTES)-1:0] offset;
        } pr;
    } fetch_addr_u;

endpackage

// File: verilog/ibuff_ptr_ctrl.sv
`timescale 1ns/1ps

module ibuff_ptr_ctrl import ibuff_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  fetch_addr_u          flush_addr,
    input  consume_t             consume_len,
    input  logic                 miss_even,
    input  logic                 miss_odd,
    input  logic [NUM_SLOTS-1:0] valid,
    input  logic                 window_valid,
    output fetch_addr_u          bip,
    output logic                 fetch_req,
    output logic [LINE_W-1:0]    fetch_line_even,
    output logic [LINE_W-1:0]    fetch_line_odd,
    output logic [NUM_SLOTS-1:0] ld,
    output logic [NUM_SLOTS-1:0] inval
);

    logic [LINE_W-2:0] pair_q;      // next pair to fetch
    logic [LINE_W-1:0] head_line;
    logic [LINE_W:0]   limit_line;  // highest line the slots may hold
    logic [1:0]        head_slot;
    logic [1:0]        slot_even;
    logic [1:0]        slot_odd;
    logic              keep_even;
    logic              in_range;
    logic              slots_free;
    logic              xfer;
    logic              consume;
    logic              crossed;
    fetch_addr_u       bip_next;

    assign head_line  = bip.ln.line;
    assign head_slot  = head_line[1:0];
    assign limit_line = {1'b0, head_line} + (LINE_W+1)'(NUM_SLOTS - 1);

    assign fetch_line_even = {pair_q, 1'b0};
    assign fetch_line_odd  = {pair_q, 1'b1};
    assign slot_even       = {pair_q[0], 1'b0};
    assign slot_odd        = {pair_q[0], 1'b1};

    // after a flush into an odd line the even half of the pair is behind the head
    assign keep_even = fetch_line_even >= head_line;
    assign in_range  = {1'b0, fetch_line_odd} <= limit_line;

    // target slots must be empty before the pair is requested
    assign slots_free = !valid[slot_odd] && !(keep_even && valid[slot_even]);

    assign fetch_req = !flush && in_range && slots_free;
    assign xfer      = fetch_req && !miss_even && !miss_odd;  // any miss blocks both banks

    always_comb begin
        ld            = '0;
        ld[slot_even] = xfer && keep_even;
        ld[slot_odd]  = xfer;             // odd line is never below the head
    end

    assign consume  = window_valid && !flush;
    assign bip_next = consume ? fetch_addr_u'(bip + ADDR_W'(consume_len)) : bip;
    assign crossed  = bip_next.ln.line != head_line;

    // head slot frees once BIP leaves its line
    always_comb begin
        inval = '0;
        if (flush) begin
            inval = '1;
        end else begin
            inval[head_slot] = consume && crossed;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bip    <= '0;
            pair_q <= '0;
        end else if (flush) begin
            bip    <= flush_addr;
            pair_q <= flush_addr.pr.pair;   // refetch starts at the pair holding the target
        end else begin
            bip <= bip_next;
            if (xfer) begin
                pair_q <= pair_q + 1'b1;
            end
        end
    end

endmodule

// File: verilog/ibuff_top.sv
`timescale 1ns/1ps

module ibuff_top import ibuff_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  fetch_addr_u       flush_addr,
    output logic              fetch_req,
    output logic [LINE_W-1:0] fetch_line_even,
    output logic [LINE_W-1:0] fetch_line_odd,
    input  line_t             line_even,
    input  line_t             line_odd,
    input  logic              miss_even,
    input  logic              miss_odd,
    input  consume_t          consume_len,
    output line_t             window,
    output logic              window_valid,
    output fetch_addr_u       window_addr
);

    logic [NUM_SLOTS-1:0]  ld;
    logic [NUM_SLOTS-1:0]  inval;
    logic [NUM_SLOTS-1:0]  valid;
    line_t [NUM_SLOTS-1:0] slot_data;
    fetch_addr_u           bip;

    assign window_addr = bip;

    ibuff_ptr_ctrl ptr_ctrl_i (
        .clk             (clk),
        .reset           (reset),
        .flush           (flush),
        .flush_addr      (flush_addr),
        .consume_len     (consume_len),
        .miss_even       (miss_even),
        .miss_odd        (miss_odd),
        .valid           (valid),
        .window_valid    (window_valid),   // consume only counts on a valid window
        .bip             (bip),
        .fetch_req       (fetch_req),
        .fetch_line_even (fetch_line_even),
        .fetch_line_odd  (fetch_line_odd),
        .ld              (ld),
        .inval           (inval)
    );

    ibuff_line_store line_store_i (
        .clk       (clk),
        .reset     (reset),
        .line_even (line_even),
        .line_odd  (line_odd),
        .ld        (ld),
        .inval     (inval),
        .valid     (valid),
        .slot_data (slot_data)
    );

    ibuff_window_align window_align_i (
        .bip          (bip),
        .slot_data    (slot_data),
        .valid        (valid),
        .window       (window),
        .window_valid (window_valid)
    );

endmodule

// File: verilog/ibuff_window_align.sv
`timescale 1ns/1ps

module ibuff_window_align import ibuff_pkg::*; (
    input  fetch_addr_u           bip,
    input  line_t [NUM_SLOTS-1:0] slot_data,
    input  logic [NUM_SLOTS-1:0]  valid,
    output line_t                 window,
    output logic                  window_valid
);

    logic [1:0]                head_slot;
    logic [1:0]                next_slot;
    line_t                     head_data;
    line_t                     next_data;
    logic [2*LINE_BYTES*8-1:0] joined;
    logic [2*LINE_BYTES*8-1:0] shifted;
    logic                      aligned;

    assign head_slot = bip.ln.line[1:0];
    assign next_slot = head_slot + 2'd1;   // wraps from slot 3 to slot 0

    assign head_data = slot_data[head_slot];
    assign next_data = slot_data[next_slot];

    // next line on top so a right shift pulls its low bytes in
    assign joined  = {next_data, head_data};
    assign shifted = joined >> {bip.ln.offset, 3'b000};
    assign window  = shifted[LINE_BYTES*8-1:0];

    assign aligned = bip.ln.offset == '0;

    // the next line only matters when the window spills past the head line
    assign window_valid = valid[head_slot] && (aligned || valid[next_slot]);

endmodule
